//--- hdl/si5338_pkg.sv
`default_nettype none

package si5338_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [6:0] command_index_t;

    typedef enum logic [2:0] {
        CMD_WRITE,   // Plain register write
        CMD_MODIFY,  // Read, merge under mask, write
        CMD_POLL,    // Read until masked data matches
        CMD_DELAY,   // Settle time
        CMD_DONE     // End of table
    } command_kind_t;

    typedef struct packed {
        command_kind_t kind;
        reg_addr_t     read_address;
        reg_addr_t     write_address;
        reg_data_t     value;
        reg_data_t     mask;  // Set bits take value, clear bits keep read data
    } command_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t address;
        reg_data_t data;
    } reg_request_t;

    typedef struct packed {
        logic      done;
        logic      nack;
        reg_data_t read_data;  // Valid with done on reads
    } reg_response_t;

    localparam int COMMAND_COUNT = 97;

    localparam reg_addr_t REG_PAGE = 8'd255;
    localparam reg_addr_t REG_OUTPUT_ENABLE = 8'd230;
    localparam reg_addr_t REG_LOL_CONTROL = 8'd241;
    localparam reg_addr_t REG_STATUS = 8'd218;
    localparam reg_addr_t REG_FCAL_CONTROL = 8'd49;
    localparam reg_addr_t REG_SOFT_RESET = 8'd246;
    localparam reg_addr_t REG_FCAL_0 = 8'd237;
    localparam reg_addr_t REG_FCAL_1 = 8'd236;
    localparam reg_addr_t REG_FCAL_2 = 8'd235;
    localparam reg_addr_t REG_FCAL_OVERRIDE_0 = 8'd47;
    localparam reg_addr_t REG_FCAL_OVERRIDE_1 = 8'd46;
    localparam reg_addr_t REG_FCAL_OVERRIDE_2 = 8'd45;

    localparam reg_data_t STATUS_CLOCK_MASK = 8'h04;  // LOS_CLKIN
    localparam reg_data_t STATUS_LOCK_MASK = 8'h11;   // PLL_LOL and SYS_CAL

    // 121.584 MHz reference plan
    localparam logic [2:0] P1DIV = 3'd2;  // P1 = 4
    localparam logic [2:0] R0DIV = 3'd0;
    localparam logic [2:0] R1DIV = 3'd0;
    localparam logic [2:0] R2DIV = 3'd0;
    localparam logic [2:0] R3DIV = 3'd0;
    localparam logic [6:0] PLL_KPHI = 7'd61;
    localparam logic [2:0] VCO_GAIN = 3'd0;
    localparam logic [1:0] RSEL = 2'd0;
    localparam logic [1:0] BWSEL = 2'd0;
    localparam logic [5:0] MSCAL = 6'd4;

    // MS0 = 20, MS1 = 9.72672, MS2 = 20, MS3 = 24.3168, MSN = 97.2672
    localparam logic [17:0] MS_P1 [5] = '{18'd2048, 18'd733, 18'd2048, 18'd2600, 18'd11938};
    localparam logic [29:0] MS_P2 [5] = '{30'd0, 30'd63, 30'd0, 30'd344, 30'd126};
    localparam logic [29:0] MS_P3 [5] = '{30'd1, 30'd3125, 30'd1, 30'd625, 30'd625};

endpackage

`default_nettype wire

//--- hdl/si5338_command_rom.sv
`default_nettype none

module si5338_command_rom (
    input  wire si5338_pkg::command_index_t index,
    output si5338_pkg::command_t            command
);

    logic [6:0] ms_offset;
    logic [2:0] ms_channel;
    logic [3:0] ms_position;

    function automatic si5338_pkg::command_t make_command(
        input si5338_pkg::command_kind_t kind,
        input si5338_pkg::reg_addr_t     read_address,
        input si5338_pkg::reg_addr_t     write_address,
        input si5338_pkg::reg_data_t     value,
        input si5338_pkg::reg_data_t     mask
    );
        make_command = '{kind, read_address, write_address, value, mask};
    endfunction

    // Full byte is a plain write, anything narrower is a modify in place
    function automatic si5338_pkg::command_t reg_write(
        input si5338_pkg::reg_addr_t address,
        input si5338_pkg::reg_data_t value,
        input si5338_pkg::reg_data_t mask
    );
        reg_write = make_command((mask == 8'hFF) ? si5338_pkg::CMD_WRITE : si5338_pkg::CMD_MODIFY,
                                 address, address, value, mask);
    endfunction

    // One byte of a MultiSynth block, channel 4 is the feedback divider N
    function automatic si5338_pkg::command_t ms_command(
        input logic [2:0] channel,
        input logic [3:0] position
    );
        logic [17:0] p1;
        logic [29:0] p2;
        logic [29:0] p3;
        si5338_pkg::reg_addr_t address;
        si5338_pkg::reg_data_t value;
        si5338_pkg::reg_data_t mask;
        p1 = si5338_pkg::MS_P1[channel];
        p2 = si5338_pkg::MS_P2[channel];
        p3 = si5338_pkg::MS_P3[channel];
        address = 8'd52 + 8'd11 * {5'd0, channel} + {4'd0, position};
        mask = 8'hFF;
        case (position)
            4'd0: begin
                value = 8'h10;  // FIDDIS = 1, no spread spectrum
                mask = 8'h7F;
            end
            4'd1: value = p1[7:0];
            4'd2: value = p1[15:8];
            4'd3: value = {p2[5:0], p1[17:16]};
            4'd4: value = p2[13:6];
            4'd5: value = p2[21:14];
            4'd6: value = p2[29:22];
            4'd7: value = p3[7:0];
            4'd8: value = p3[15:8];
            4'd9: value = p3[23:16];
            default: begin
                value = {(channel == 3'd4) ? 2'b10 : 2'b00, p3[29:24]};
                mask = (channel == 3'd4) ? 8'hBF : 8'h3F;
            end
        endcase
        return reg_write(address, value, mask);
    endfunction

    always_comb begin
        ms_offset = index - 7'd15;
        if (index >= 7'd59) begin
            ms_channel = 3'd4;  // N block has no config byte
            ms_position = 4'(index - 7'd58);
        end else begin
            ms_channel = 3'(ms_offset / 7'd11);
            ms_position = 4'(ms_offset % 7'd11);
        end
    end

    always_comb begin
        command = make_command(si5338_pkg::CMD_DONE, 8'd0, 8'd0, 8'd0, 8'd0);
        if (int'(index) < si5338_pkg::COMMAND_COUNT) begin
            case (index) inside
                7'd0: command = reg_write(si5338_pkg::REG_PAGE, 8'h00, 8'hFF);
                7'd1: command = reg_write(si5338_pkg::REG_OUTPUT_ENABLE, 8'h10, 8'hFF);
                7'd2: command = reg_write(si5338_pkg::REG_LOL_CONTROL, 8'hE5, 8'hFF);  // DIS_LOL
                7'd3: command = reg_write(8'd6, 8'h08, 8'h1D);  // Alarm masks
                7'd4: command = reg_write(8'd28, 8'h00, 8'hFF);
                7'd5: command = reg_write(8'd29, {5'b01000, si5338_pkg::P1DIV}, 8'hFF);
                7'd6: command = reg_write(8'd30, 8'hB0, 8'hFF);
                7'd7: command = reg_write(8'd31, {3'b110, si5338_pkg::R0DIV, 2'b00}, 8'hFF);
                7'd8: command = reg_write(8'd32, {3'b110, si5338_pkg::R1DIV, 2'b00}, 8'hFF);
                7'd9: command = reg_write(8'd33, {3'b110, si5338_pkg::R2DIV, 2'b00}, 8'hFF);
                7'd10: command = reg_write(8'd34, {3'b110, si5338_pkg::R3DIV, 2'b00}, 8'hFF);
                7'd11: command = reg_write(8'd48, {1'b0, si5338_pkg::PLL_KPHI}, 8'hFF);
                7'd12: command = reg_write(si5338_pkg::REG_FCAL_CONTROL,
                    {1'b0, si5338_pkg::VCO_GAIN, si5338_pkg::RSEL, si5338_pkg::BWSEL}, 8'hFF);
                7'd13: command = reg_write(8'd50, {2'b11, si5338_pkg::MSCAL}, 8'hFF);
                7'd14: command = reg_write(8'd51, 8'h07, 8'hFF);
                [7'd15:7'd68]: command = ms_command(ms_channel, ms_position);
                // Phase offset, phase step and DISST bytes of the four channels
                [7'd69:7'd84]: command = reg_write(8'd38 + {1'b0, index},
                    (index == 7'd78) ? 8'h80 : 8'h00,
                    (index == 7'd70 || index == 7'd74) ? 8'h7F : 8'hFF);
                7'd85: command = reg_write(8'd242, 8'h02, 8'h02);  // DCLK_DIS
                7'd86: command = make_command(si5338_pkg::CMD_POLL, si5338_pkg::REG_STATUS,
                    si5338_pkg::REG_STATUS, 8'h00, si5338_pkg::STATUS_CLOCK_MASK);
                7'd87: command = reg_write(si5338_pkg::REG_FCAL_CONTROL, 8'h00, 8'h80);
                7'd88: command = reg_write(si5338_pkg::REG_SOFT_RESET, 8'h02, 8'hFF);
                7'd89: command = make_command(si5338_pkg::CMD_DELAY, 8'd0, 8'd0, 8'd0, 8'd0);
                7'd90: command = reg_write(si5338_pkg::REG_LOL_CONTROL, 8'h65, 8'hFF);
                7'd91: command = make_command(si5338_pkg::CMD_POLL, si5338_pkg::REG_STATUS,
                    si5338_pkg::REG_STATUS, 8'h00, si5338_pkg::STATUS_LOCK_MASK);
                // Calibration copies, the first keeps only two bits of 237
                7'd92: command = make_command(si5338_pkg::CMD_MODIFY, si5338_pkg::REG_FCAL_0,
                    si5338_pkg::REG_FCAL_OVERRIDE_0, 8'h14, 8'hFC);
                7'd93: command = make_command(si5338_pkg::CMD_MODIFY, si5338_pkg::REG_FCAL_1,
                    si5338_pkg::REG_FCAL_OVERRIDE_1, 8'h00, 8'h00);
                7'd94: command = make_command(si5338_pkg::CMD_MODIFY, si5338_pkg::REG_FCAL_2,
                    si5338_pkg::REG_FCAL_OVERRIDE_2, 8'h00, 8'h00);
                7'd95: command = reg_write(si5338_pkg::REG_FCAL_CONTROL, 8'h80, 8'h80);
                7'd96: command = reg_write(si5338_pkg::REG_OUTPUT_ENABLE, 8'h00, 8'hFF);
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/si5338_reg_access.sv
`default_nettype none

module si5338_reg_access (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            start,
    input  wire si5338_pkg::command_t      command,
    output logic                           finished,
    output logic                           failed,
    output si5338_pkg::reg_request_t       reg_request,
    input  wire si5338_pkg::reg_response_t reg_response
);

    typedef enum logic [2:0] {IDLE, WRITE, READ, POLL, FINISH} state_t;

    state_t state;
    si5338_pkg::reg_data_t merged;
    logic match;

    assign merged = (reg_response.read_data & ~command.mask) | (command.value & command.mask);
    assign match = (reg_response.read_data & command.mask) == (command.value & command.mask);
    assign finished = state == FINISH;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            reg_request.valid <= 1'b0;
            failed <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        failed <= 1'b0;
                        case (command.kind)
                            si5338_pkg::CMD_WRITE: begin
                                reg_request.write <= 1'b1;
                                reg_request.address <= command.write_address;
                                reg_request.data <= command.value;
                                state <= WRITE;
                            end
                            si5338_pkg::CMD_MODIFY: begin
                                reg_request.write <= 1'b0;
                                reg_request.address <= command.read_address;
                                state <= READ;
                            end
                            si5338_pkg::CMD_POLL: begin
                                reg_request.write <= 1'b0;
                                reg_request.address <= command.read_address;
                                state <= POLL;
                            end
                            default: state <= FINISH;  // No bus work
                        endcase
                    end
                end
                WRITE, READ, POLL: begin
                    // Valid rises one cycle after the fields settle
                    if (!reg_request.valid) begin
                        reg_request.valid <= 1'b1;
                    end else if (reg_response.done) begin
                        reg_request.valid <= 1'b0;
                        if (reg_response.nack) begin
                            failed <= 1'b1;
                            state <= FINISH;
                        end else if (state == READ) begin
                            reg_request.write <= 1'b1;  // Write half of the modify
                            reg_request.address <= command.write_address;
                            reg_request.data <= merged;
                            state <= WRITE;
                        end else if (state == WRITE || match) begin
                            state <= FINISH;
                        end
                    end
                end
                default: state <= IDLE;  // FINISH lasts one cycle
            endcase
        end
    end

    // An outstanding request holds until the responder answers
    request_held: assert property (@(posedge clock) disable iff (reset)
        reg_request.valid && !reg_response.done |=> $stable(reg_request));

endmodule

`default_nettype wire

//--- hdl/si5338_sequencer.sv
`default_nettype none

module si5338_sequencer #(
    parameter int WAIT_CYCLES = 2_500_000
) (
    input  wire                         clock,
    input  wire                         reset,
    input  wire si5338_pkg::command_t   command,
    output si5338_pkg::command_index_t  index,
    output logic                        start,
    input  wire                         finished,
    input  wire                         failed,
    output logic                        ready
);

    typedef enum logic [1:0] {FETCH, ISSUE, DELAY, READY} state_t;
    typedef logic [$clog2(WAIT_CYCLES + 1) - 1:0] wait_count_t;

    state_t state;
    wait_count_t wait_count;

    assign start = state == ISSUE;
    assign ready = state == READY;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= FETCH;
            index <= '0;
            wait_count <= '0;
        end else begin
            case (state)
                FETCH: begin
                    case (command.kind)
                        si5338_pkg::CMD_DELAY: begin
                            wait_count <= wait_count_t'(WAIT_CYCLES - 1);
                            state <= DELAY;
                        end
                        si5338_pkg::CMD_DONE: state <= READY;
                        default: state <= ISSUE;
                    endcase
                end
                ISSUE: begin
                    if (finished) begin
                        // Any NACK restarts the whole table
                        index <= failed ? '0 : index + 7'd1;
                        state <= FETCH;
                    end
                end
                DELAY: begin
                    if (wait_count == '0) begin
                        index <= index + 7'd1;
                        state <= FETCH;
                    end else begin
                        wait_count <= wait_count - wait_count_t'(1);
                    end
                end
                default: state <= READY;  // Stays until reset
            endcase
        end
    end

    ready_sticky: assert property (@(posedge clock) disable iff (reset) ready |=> ready);

endmodule

`default_nettype wire

//--- hdl/si5338_init.sv
`default_nettype none

module si5338_init #(
    parameter int WAIT_CYCLES = 2_500_000  // 25 ms at 100 MHz
) (
    input  wire                            clock,
    input  wire                            reset,
    output si5338_pkg::reg_request_t       reg_request,
    input  wire si5338_pkg::reg_response_t reg_response,
    output logic                           ready
);

    si5338_pkg::command_index_t index;
    si5338_pkg::command_t command;
    logic start;
    logic finished;
    logic failed;

    si5338_sequencer #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) si5338_sequencer_i (
        .clock(clock),
        .reset(reset),
        .command(command),
        .index(index),
        .start(start),
        .finished(finished),
        .failed(failed),
        .ready(ready)
    );

    si5338_command_rom si5338_command_rom_i (
        .index(index),
        .command(command)
    );

    si5338_reg_access si5338_reg_access_i (
        .clock(clock),
        .reset(reset),
        .start(start),
        .command(command),
        .finished(finished),
        .failed(failed),
        .reg_request(reg_request),
        .reg_response(reg_response)
    );

endmodule

`default_nettype wire

//--- sim/si5338_init_checker.sv
`default_nettype none

module si5338_init_checker #(
    parameter int WAIT_CYCLES = 50
) (
    input  wire                            clock,
    input  wire                            reset,
    input  wire si5338_pkg::reg_request_t  reg_request,
    input  wire si5338_pkg::reg_response_t reg_response,
    input  wire                            ready,
    output int                             error_count
);

    // Scenario under test
    string test_name = "none";
    int expected_restarts = 0;
    int busy_reads = 0;
    logic [7:0] initial_reg6 = 8'h00;
    logic [7:0] source_235 = 8'h00;
    logic [7:0] source_236 = 8'h00;
    logic [7:0] source_237 = 8'h00;

    logic [7:0] image [256];  // Last value written per address
    logic written [256];
    int errors = 0;
    int cycle = 0;
    int restarts = 0;
    int status_reads = 0;
    int status_reads_at_reset = -1;
    int soft_reset_cycle = -1;
    logic expect_page = 1'b0;  // Next transaction must be the page write
    logic idle_check = 1'b0;
    logic valid_prev = 1'b0;
    logic ready_prev = 1'b0;

    assign error_count = errors;

    task automatic begin_test(
        input string      name,
        input int         restarts_expected,
        input int         busy,
        input logic [7:0] reg6,
        input logic [7:0] fcal_235,
        input logic [7:0] fcal_236,
        input logic [7:0] fcal_237
    );
        test_name = name;
        expected_restarts = restarts_expected;
        busy_reads = busy;
        initial_reg6 = reg6;
        source_235 = fcal_235;
        source_236 = fcal_236;
        source_237 = fcal_237;
    endtask

    task automatic check_byte(input string what, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: %s expected 0x%02h actual 0x%02h",
                     test_name, what, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic check_at_least(input string what, input int minimum, input int actual);
        if (actual < minimum) begin
            $display("FAILED %s: %s expected at least %0d actual %0d",
                     test_name, what, minimum, actual);
            errors = errors + 1;
        end
    endtask

    task automatic check_register(input string what, input si5338_pkg::reg_addr_t address,
                                  input logic [7:0] expected);
        if (!written[address]) begin
            $display("Error in %s: register %0d was never written", test_name, address);
            errors = errors + 1;
        end else begin
            check_byte(what, expected, image[address]);
        end
    endtask

    // Final register image and counts at the rise of ready
    task automatic check_final();
        if (soft_reset_cycle < 0) begin
            $display("Error in %s: ready rose without a soft-reset write", test_name);
            errors = errors + 1;
        end else begin
            check_at_least("cycles from soft reset to ready", WAIT_CYCLES,
                           cycle - soft_reset_cycle);
        end
        check_register("output enable", si5338_pkg::REG_OUTPUT_ENABLE, 8'h00);
        check_register("loss-of-lock control", si5338_pkg::REG_LOL_CONTROL, 8'h65);
        check_register("FCAL control", si5338_pkg::REG_FCAL_CONTROL, 8'h80);
        check_register("soft reset", si5338_pkg::REG_SOFT_RESET, 8'h02);
        check_register("register 6", 8'd6, (initial_reg6 & ~8'h1D) | 8'h08);
        check_register("FCAL override 45", si5338_pkg::REG_FCAL_OVERRIDE_2, source_235);
        check_register("FCAL override 46", si5338_pkg::REG_FCAL_OVERRIDE_1, source_236);
        check_register("FCAL override 47", si5338_pkg::REG_FCAL_OVERRIDE_0,
                       8'h14 | (source_237 & 8'h03));
        check_byte("restart count", 8'(expected_restarts), 8'(restarts));
        check_at_least("status reads before soft reset", busy_reads + 1, status_reads_at_reset);
    endtask

    always @(posedge clock) begin
        cycle = cycle + 1;
        if (reset) begin
            foreach (written[i]) begin
                written[i] = 1'b0;
            end
            restarts = -1;  // The first page write starts the table
            status_reads = 0;
            status_reads_at_reset = -1;
            soft_reset_cycle = -1;
            expect_page = 1'b0;
            idle_check = 1'b0;
            valid_prev = 1'b0;
            ready_prev = 1'b0;
        end else begin
            // First request after the soft reset ends the quiet period
            if (reg_request.valid && !valid_prev && idle_check) begin
                check_at_least("idle cycles after soft reset", WAIT_CYCLES,
                               cycle - soft_reset_cycle);
                idle_check = 1'b0;
            end
            if (reg_request.valid && reg_response.done) begin
                if (expect_page) begin
                    if (!reg_request.write) begin
                        $display("Error in %s: a read followed the NACK instead of the page write",
                                 test_name);
                        errors = errors + 1;
                    end else begin
                        check_byte("address after NACK", si5338_pkg::REG_PAGE,
                                   reg_request.address);
                    end
                    expect_page = 1'b0;
                end
                if (reg_response.nack) begin
                    expect_page = 1'b1;
                end else if (reg_request.write) begin
                    image[reg_request.address] = reg_request.data;
                    written[reg_request.address] = 1'b1;
                    if (reg_request.address == si5338_pkg::REG_PAGE) begin
                        restarts = restarts + 1;  // Entry 0 runs again
                    end
                    if (reg_request.address == si5338_pkg::REG_SOFT_RESET) begin
                        if (status_reads_at_reset < 0) begin
                            status_reads_at_reset = status_reads;
                        end
                        soft_reset_cycle = cycle;
                        idle_check = 1'b1;
                    end
                end else if (reg_request.address == si5338_pkg::REG_STATUS) begin
                    status_reads = status_reads + 1;
                end
            end
            if (ready && !ready_prev) begin
                check_final();
            end
            valid_prev = reg_request.valid;
            ready_prev = ready;
        end
    end

endmodule

`default_nettype wire

//--- sim/si5338_init_tb.sv
`default_nettype none

module si5338_init_tb;

    localparam int WAIT_CYCLES = 50;
    localparam int TEST_COUNT = 5;
    localparam int READY_TIMEOUT = 20000;  // Cycles per test

    // Scenario table: name, NACKed transaction (0 for none), busy status reads,
    // values of registers 235, 236, 237, expected restarts
    string test_names [TEST_COUNT] = '{"plain_run", "nack_on_modify_read",
        "nack_with_busy_status", "nack_on_fcal_copy", "busy_status"};
    int nack_at [TEST_COUNT] = '{0, 4, 37, 106, 0};
    int busy_reads [TEST_COUNT] = '{0, 0, 5, 0, 9};
    logic [7:0] fcal_values [TEST_COUNT][3] = '{'{8'h5a, 8'hc3, 8'h81},
        '{8'h00, 8'hff, 8'h7e}, '{8'h3c, 8'h12, 8'hfd}, '{8'ha5, 8'h96, 8'h02},
        '{8'h47, 8'h00, 8'h03}};
    int expected_restarts [TEST_COUNT] = '{0, 1, 1, 1, 0};

    logic clock = 1'b0;
    logic reset = 1'b1;
    si5338_pkg::reg_request_t reg_request;
    si5338_pkg::reg_response_t reg_response = '0;
    logic ready;
    int error_count;
    int timeouts = 0;
    int row = 0;

    // Bus responder state
    integer seed = 32'h1a440d5f;
    logic [7:0] reg_file [256];
    logic reset_seen;
    int row_seen;
    logic loaded = 1'b0;
    logic waiting = 1'b0;
    int wait_left = 0;
    int transactions = 0;
    int status_busy_left = 0;

    always #5 clock = ~clock;

    si5338_init #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) si5338_init_i (
        .clock(clock),
        .reset(reset),
        .reg_request(reg_request),
        .reg_response(reg_response),
        .ready(ready)
    );

    si5338_init_checker #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) si5338_init_checker_i (
        .clock(clock),
        .reset(reset),
        .reg_request(reg_request),
        .reg_response(reg_response),
        .ready(ready),
        .error_count(error_count)
    );

    task automatic load_scenario();
        foreach (reg_file[i]) begin
            reg_file[i] = 8'($random(seed));
        end
        reg_file[si5338_pkg::REG_FCAL_2] = fcal_values[row_seen][0];  // 235
        reg_file[si5338_pkg::REG_FCAL_1] = fcal_values[row_seen][1];
        reg_file[si5338_pkg::REG_FCAL_0] = fcal_values[row_seen][2];
        transactions = 0;
        status_busy_left = busy_reads[row_seen];
    endtask

    task automatic answer_request();
        transactions = transactions + 1;
        if (transactions == nack_at[row_seen]) begin
            reg_response.nack = 1'b1;  // Register file left untouched
        end else if (reg_request.write) begin
            reg_file[reg_request.address] = reg_request.data;
        end else if (reg_request.address == si5338_pkg::REG_STATUS) begin
            // Clock and lock bits stay set while busy
            reg_response.read_data = (status_busy_left > 0) ? 8'h15 : 8'h00;
            if (status_busy_left > 0) begin
                status_busy_left = status_busy_left - 1;
            end
        end else begin
            reg_response.read_data = reg_file[reg_request.address];
        end
        reg_response.done = 1'b1;
    endtask

    // Register file on the bus, 1 to 4 cycles per transaction
    always @(posedge clock) begin
        reset_seen = reset;
        row_seen = row;
        #1;
        reg_response.done = 1'b0;
        reg_response.nack = 1'b0;
        if (reset_seen) begin
            if (!loaded) begin
                load_scenario();
            end
            loaded = 1'b1;
            waiting = 1'b0;
        end else begin
            loaded = 1'b0;
            if (!reg_request.valid) begin
                waiting = 1'b0;
            end else begin
                if (!waiting) begin
                    waiting = 1'b1;
                    wait_left = 1 + ($random(seed) & 3);
                end
                wait_left = wait_left - 1;
                if (wait_left == 0) begin
                    answer_request();
                    waiting = 1'b0;
                end
            end
        end
    end

    task automatic run_test(input int t);
        int waited;
        waited = 0;
        row = t;
        reset = 1'b1;
        repeat (5) begin
            @(posedge clock);
        end
        #1;
        si5338_init_checker_i.begin_test(test_names[t], expected_restarts[t], busy_reads[t],
            reg_file[6], fcal_values[t][0], fcal_values[t][1], fcal_values[t][2]);
        reset = 1'b0;
        while (!ready && waited < READY_TIMEOUT) begin
            @(posedge clock);
            #1;
            waited = waited + 1;
        end
        if (!ready) begin
            $display("Timeout in %s: ready did not rise within %0d cycles",
                     test_names[t], READY_TIMEOUT);
            timeouts = timeouts + 1;
        end
        @(posedge clock);  // Checker sees the ready edge
        #1;
    endtask

    initial begin
        for (int t = 0; t < TEST_COUNT; t++) begin
            run_test(t);
        end
        $display("tests %0d, errors %0d, timeouts %0d", TEST_COUNT, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- si5338_init.f
hdl/si5338_pkg.sv
hdl/si5338_command_rom.sv
hdl/si5338_reg_access.sv
hdl/si5338_sequencer.sv
hdl/si5338_init.sv
sim/si5338_init_checker.sv
sim/si5338_init_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the si5338_init testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module si5338_init_tb -f si5338_init.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vsi5338_init_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
